// ==== Bender.yml ====
package:
  name: hdc_bundle

sources:
  # package first, then leaf modules, then the top level
  - design/hdc_pkg.sv
  - design/hv_encoder.sv
  - design/bus_arbiter.sv
  - design/dim_counter.sv
  - design/bundle_buffer.sv
  - design/hdc_bundle_top.sv

  - target: simulation
    files:
      - testbench/clk_rst_gen.sv
      - testbench/tb_hdc_bundle.sv

// ==== all.f ====
design/hdc_pkg.sv
design/hv_encoder.sv
design/bus_arbiter.sv
design/dim_counter.sv
design/bundle_buffer.sv
design/hdc_bundle_top.sv
testbench/clk_rst_gen.sv
testbench/tb_hdc_bundle.sv

// ==== design/bundle_buffer.sv ====
`default_nettype none

module bundle_buffer
    import hdc_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,

    // accumulation side
    input  logic             clear_i,
    input  logic             store_i,
    input  logic [DIM-1:0]   store_hv_i,

    // software readout
    input  logic             stream_v_i,
    input  logic [IDX_W-1:0] stream_idx_i,
    output logic [31:0]      stream_d_o,
    output logic             stream_dv_o
);

    logic [DIM-1:0]          sign_hv;
    logic [WORDS-1:0][31:0]  sign_words;
    logic [31:0]             stream_d_q;
    logic                    stream_dv_q;

    // one majority counter per dimension
    for (genvar d = 0; d < DIM; d++) begin : g_dim
        dim_counter u_cnt (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .clear_i (clear_i),
            .store_i (store_i),
            .bit_i   (store_hv_i[d]),
            .sign_o  (sign_hv[d])
        );
    end

    // bundled vector seen as 32-bit words, word 0 at bit 0
    assign sign_words = sign_hv;

    // word register, loaded only on a read strobe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stream_d_q <= '0;
        end else if (stream_v_i) begin
            stream_d_q <= sign_words[stream_idx_i];
        end
    end

    // valid follows the strobe by one cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stream_dv_q <= 1'b0;
        end else begin
            stream_dv_q <= stream_v_i;
        end
    end

    assign stream_d_o  = stream_d_q;
    assign stream_dv_o = stream_dv_q;

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter
    import hdc_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n_i,

    // requests and hypervectors of all cores
    input  logic [NUM_CORES-1:0]              req_i,
    input  logic [NUM_CORES-1:0][DIM-1:0]     hv_i,
    output logic [NUM_CORES-1:0]              grant_o,

    // shared store bus into the bundle buffer
    output logic                              store_o,
    output logic [DIM-1:0]                    store_hv_o
);

    localparam int PTR_W = $clog2(NUM_CORES);

    logic [PTR_W-1:0] last_q;
    logic [PTR_W-1:0] win_idx;
    logic             win_vld;
    logic             store_q;
    logic [DIM-1:0]   store_hv_q;

    // search starts one past the previous winner
    always_comb begin
        win_idx = last_q;
        win_vld = 1'b0;
        for (int i = 1; i <= NUM_CORES; i++) begin
            if (!win_vld && req_i[(int'(last_q) + i) % NUM_CORES]) begin
                win_idx = PTR_W'((int'(last_q) + i) % NUM_CORES);
                win_vld = 1'b1;
            end
        end
    end

    // one-hot grant, same cycle as the pick
    assign grant_o = win_vld ? (NUM_CORES'(1) << win_idx) : '0;

    // pointer and store pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // core 0 wins first after reset
            last_q  <= PTR_W'(NUM_CORES - 1);
            store_q <= 1'b0;
        end else begin
            store_q <= win_vld;
            if (win_vld) begin
                last_q <= win_idx;
            end
        end
    end

    // winner's hypervector, valid alongside the store pulse
    always_ff @(posedge clk) begin
        if (win_vld) begin
            store_hv_q <= hv_i[win_idx];
        end
    end

    assign store_o    = store_q;
    assign store_hv_o = store_hv_q;

endmodule

`default_nettype wire

// ==== design/dim_counter.sv ====
`default_nettype none

module dim_counter
    import hdc_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,

    input  logic clear_i,
    input  logic store_i,
    input  logic bit_i,

    output logic sign_o
);

    // two's complement limits
    localparam logic signed [COUNT_W-1:0] CNT_MAX = {1'b0, {(COUNT_W-1){1'b1}}};
    localparam logic signed [COUNT_W-1:0] CNT_MIN = {1'b1, {(COUNT_W-1){1'b0}}};

    logic signed [COUNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            // clear wins over a store in the same cycle
            cnt_q <= '0;
        end else if (store_i) begin
            if (bit_i && cnt_q != CNT_MAX) begin
                cnt_q <= cnt_q + COUNT_W'(1);
            end else if (!bit_i && cnt_q != CNT_MIN) begin
                cnt_q <= cnt_q - COUNT_W'(1);
            end
        end
    end

    // strictly positive count votes 1, ties vote 0
    assign sign_o = (cnt_q > 0);

endmodule

`default_nettype wire

// ==== design/hdc_bundle_top.sv ====
`default_nettype none

module hdc_bundle_top
    import hdc_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n_i,

    // per-core symbol inputs
    input  logic [NUM_CORES-1:0]            sample_v_i,
    input  logic [NUM_CORES-1:0][SYM_W-1:0] sample_i,
    output logic [NUM_CORES-1:0]            busy_o,

    input  logic                            clear_i,

    // readout port
    input  logic                            stream_v_i,
    input  logic [IDX_W-1:0]                stream_idx_i,
    output logic [31:0]                     stream_d_o,
    output logic                            stream_dv_o
);

    logic [NUM_CORES-1:0]          enc_req;
    logic [NUM_CORES-1:0][DIM-1:0] enc_hv;
    logic [NUM_CORES-1:0]          enc_grant;
    logic                          bus_store;
    logic [DIM-1:0]                bus_store_hv;

    // encoder cores
    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        hv_encoder #(
            .CORE_ID (c)
        ) u_enc (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .sample_v_i (sample_v_i[c]),
            .sample_i   (sample_i[c]),
            .grant_i    (enc_grant[c]),
            .req_o      (enc_req[c]),
            .hv_o       (enc_hv[c]),
            .busy_o     (busy_o[c])
        );
    end

    // shared bus arbitration
    bus_arbiter u_arb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (enc_req),
        .hv_i       (enc_hv),
        .grant_o    (enc_grant),
        .store_o    (bus_store),
        .store_hv_o (bus_store_hv)
    );

    // majority accumulation and readout
    bundle_buffer u_buf (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .clear_i      (clear_i),
        .store_i      (bus_store),
        .store_hv_i   (bus_store_hv),
        .stream_v_i   (stream_v_i),
        .stream_idx_i (stream_idx_i),
        .stream_d_o   (stream_d_o),
        .stream_dv_o  (stream_dv_o)
    );

endmodule

`default_nettype wire

// ==== design/hdc_pkg.sv ====
`default_nettype none

package hdc_pkg;

    // hypervector geometry
    localparam int DIM   = 256;
    localparam int WORDS = DIM / 32;
    localparam int IDX_W = 3;

    // encoder cores sharing the store bus
    localparam int NUM_CORES = 4;
    localparam int SYM_W     = 8;

    // signed per-dimension counter, -128 .. 127
    localparam int COUNT_W = 8;

    // item memory seed, also the base of every core key
    localparam logic [DIM-1:0] SEED_HV =
        256'h9e3779b9_7f4a7c15_f39cc060_5cedc834_1082276b_f3a27251_f86c6a11_d0c18e95;

    // key of core c is the seed rotated left by c * KEY_SHIFT
    localparam int KEY_SHIFT = 37;

    // left rotation of a hypervector, amount taken modulo DIM
    function automatic logic [DIM-1:0] rotl_hv(input logic [DIM-1:0] hv, input int unsigned amt);
        int unsigned s;
        s = amt % DIM;
        return (hv << s) | (hv >> (DIM - s));
    endfunction

endpackage

`default_nettype wire

// ==== design/hv_encoder.sv ====
`default_nettype none

module hv_encoder
    import hdc_pkg::*;
#(
    parameter int unsigned CORE_ID = 0
) (
    input  logic             clk,
    input  logic             rst_n_i,

    // symbol strobe from the sampler
    input  logic             sample_v_i,
    input  logic [SYM_W-1:0] sample_i,

    // bus request towards the arbiter
    input  logic             grant_i,
    output logic             req_o,
    output logic [DIM-1:0]   hv_o,

    output logic             busy_o
);

    // per-core binding key, fixed at elaboration
    localparam logic [DIM-1:0] KEY_HV = rotl_hv(SEED_HV, CORE_ID * KEY_SHIFT);

    logic             pend_q;
    logic [SYM_W-1:0] sym_q;
    logic             accept;
    logic [DIM-1:0]   perm_hv;

    // new symbols only while idle, strobes during busy are lost
    assign accept = sample_v_i && !pend_q;

    // pending flag doubles as request and busy level
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else if (accept) begin
            pend_q <= 1'b1;
        end else if (grant_i) begin
            // grant seen this cycle, store goes out on the bus next cycle
            pend_q <= 1'b0;
        end
    end

    // symbol register
    always_ff @(posedge clk) begin
        if (accept) begin
            sym_q <= sample_i;
        end
    end

    // permute the seed by the symbol
    assign perm_hv = rotl_hv(SEED_HV, sym_q);

    // bind with the core key
    assign hv_o = perm_hv ^ KEY_HV;

    assign req_o  = pend_q;
    assign busy_o = pend_q;

endmodule

`default_nettype wire

// ==== testbench/clk_rst_gen.sv ====
`default_nettype none

module clk_rst_gen #(
    parameter int PERIOD      = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_hdc_bundle.sv ====
`default_nettype none

module tb_hdc_bundle
    import hdc_pkg::*;
;

    localparam int TIMEOUT = 100;

    logic                            clk;
    logic                            rst_n;
    logic [NUM_CORES-1:0]            sample_v_i;
    logic [NUM_CORES-1:0][SYM_W-1:0] sample_i;
    logic [NUM_CORES-1:0]            busy_o;
    logic                            clear_i;
    logic                            stream_v_i;
    logic [IDX_W-1:0]                stream_idx_i;
    logic [31:0]                     stream_d_o;
    logic                            stream_dv_o;

    // reference counts, one per dimension
    int cnt_model [DIM];
    int errors;
    int checks;
    int tests;
    int failed;
    int err_mark;

    clk_rst_gen #(.PERIOD(20), .RESET_CYCLES(2)) u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    hdc_bundle_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .sample_v_i   (sample_v_i),
        .sample_i     (sample_i),
        .busy_o       (busy_o),
        .clear_i      (clear_i),
        .stream_v_i   (stream_v_i),
        .stream_idx_i (stream_idx_i),
        .stream_d_o   (stream_d_o),
        .stream_dv_o  (stream_dv_o)
    );

    // bit i of the input lands on bit i+amt
    function automatic logic [DIM-1:0] rotate_left(logic [DIM-1:0] v, int amt);
        logic [DIM-1:0] r;
        for (int i = 0; i < DIM; i++) begin
            r[(i + amt) % DIM] = v[i];
        end
        return r;
    endfunction

    function automatic logic [DIM-1:0] encode_hv(int core, logic [SYM_W-1:0] sym);
        return rotate_left(SEED_HV, int'(sym)) ^ rotate_left(SEED_HV, core * KEY_SHIFT);
    endfunction

    function automatic logic [31:0] model_word(int idx);
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            w[b] = (cnt_model[32 * idx + b] > 0);
        end
        return w;
    endfunction

    task automatic model_store(int core, logic [SYM_W-1:0] sym);
        logic [DIM-1:0] hv;
        hv = encode_hv(core, sym);
        for (int d = 0; d < DIM; d++) begin
            if (hv[d] && cnt_model[d] < 127) begin
                cnt_model[d]++;
            end else if (!hv[d] && cnt_model[d] > -128) begin
                cnt_model[d]--;
            end
        end
    endtask

    task automatic model_clear();
        for (int d = 0; d < DIM; d++) begin
            cnt_model[d] = 0;
        end
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout at time %0t: %s", $time, what);
        errors++;
    endtask

    // inputs change 2 units after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy_o != '0 && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (busy_o != '0) begin
            report_timeout("busy_o stayed high after waiting 100 cycles");
        end
    endtask

    task automatic read_word(int idx, output logic [31:0] data);
        int n;
        stream_v_i   = 1'b1;
        stream_idx_i = IDX_W'(idx);
        next_cycle();
        stream_v_i = 1'b0;
        n = 1;
        while (!stream_dv_o && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        data = stream_d_o;
        if (!stream_dv_o) begin
            report_timeout("stream_dv_o never rose after a read strobe");
        end else begin
            checks++;
            assert (n == 1) else begin
                $display("stream_dv_o came %0d cycles after the read strobe, not 1", n);
                errors++;
            end
        end
        // valid is a single-cycle pulse
        next_cycle();
        check_value("stream_dv_o", 32'(stream_dv_o), 32'h0);
    endtask

    task automatic check_readout();
        logic [31:0] got;
        wait_idle();
        repeat (2) next_cycle();
        for (int w = 0; w < WORDS; w++) begin
            read_word(w, got);
            check_value($sformatf("stream_d_o[word %0d]", w), got, model_word(w));
        end
    endtask

    // one accepted symbol on one idle core
    task automatic store_one(int core, logic [SYM_W-1:0] sym);
        sample_v_i[core] = 1'b1;
        sample_i[core]   = sym;
        model_store(core, sym);
        next_cycle();
        sample_v_i = '0;
        check_value("busy_o after strobe", 32'(busy_o[core]), 32'h1);
        wait_idle();
    endtask

    task automatic strobe_all();
        logic [SYM_W-1:0] sym;
        for (int c = 0; c < NUM_CORES; c++) begin
            sym           = SYM_W'($urandom());
            sample_v_i[c] = 1'b1;
            sample_i[c]   = sym;
            model_store(c, sym);
        end
        next_cycle();
        sample_v_i = '0;
    endtask

    task automatic finish_test(string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [SYM_W-1:0] sym_a;
        logic [SYM_W-1:0] sym_b;
        int n;
        void'($urandom(25497));
        sample_v_i   = '0;
        sample_i     = '0;
        clear_i      = 1'b0;
        stream_v_i   = 1'b0;
        stream_idx_i = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        failed   = 0;
        err_mark = 0;
        model_clear();

        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset was never released");
        end
        next_cycle();

        check_value("busy_o", 32'(busy_o), 32'h0);
        check_readout();
        finish_test("reset");

        store_one($urandom_range(NUM_CORES - 1, 0), SYM_W'($urandom()));
        check_readout();
        finish_test("single store");

        // at most 81 stores so far, so no counter can saturate
        for (int r = 0; r < 20; r++) begin
            strobe_all();
            check_value("busy_o after strobe", 32'(busy_o), 32'hF);
            wait_idle();
            if (r % 5 == 4) begin
                check_readout();
            end
        end
        finish_test("contention");

        // second strobe lands while every core is still busy
        for (int r = 0; r < 8; r++) begin
            strobe_all();
            check_value("busy_o before dropped strobe", 32'(busy_o), 32'hF);
            sample_v_i = '1;
            for (int c = 0; c < NUM_CORES; c++) begin
                sample_i[c] = SYM_W'($urandom());
            end
            next_cycle();
            sample_v_i = '0;
            wait_idle();
        end
        check_readout();
        finish_test("busy drop");

        sym_a = SYM_W'($urandom());
        sym_b = SYM_W'($urandom());
        repeat (140) store_one(0, sym_a);
        check_readout();
        // opposite votes pull saturated counts back, many to exactly zero
        repeat (127) store_one(1, sym_b);
        check_readout();
        repeat (30) store_one($urandom_range(NUM_CORES - 1, 0), SYM_W'($urandom()));
        check_readout();
        finish_test("saturation and ties");

        // clear lands on the same edge as the bus store
        sample_v_i[2] = 1'b1;
        sample_i[2]   = SYM_W'($urandom());
        next_cycle();
        sample_v_i = '0;
        next_cycle();
        clear_i = 1'b1;
        next_cycle();
        clear_i = 1'b0;
        model_clear();
        check_readout();
        store_one(3, SYM_W'($urandom()));
        check_readout();
        clear_i = 1'b1;
        next_cycle();
        clear_i = 1'b0;
        model_clear();
        check_readout();
        finish_test("clear");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
